// ==== hdl/feature_pkg.sv ====
// waveform feature definitions
`default_nettype none

package feature_pkg;

    // ==================================================
    // samples and windows
    // ==================================================
    localparam int sample_bits  = 11;
    localparam int window_len   = 256;
    localparam int window_shift = 8;    // log2 of window_len

    typedef logic signed [sample_bits-1:0] sample_t;
    typedef logic [window_shift-1:0]       count_t;   // index within a window
    typedef logic signed [31:0]            sum_t;

    // identity values for the peak trackers
    localparam sample_t sample_min = {1'b1, {(sample_bits-1){1'b0}}};
    localparam sample_t sample_max = {1'b0, {(sample_bits-1){1'b1}}};

    // ==================================================
    // features and division
    // ==================================================
    typedef logic [15:0]        feature_t;
    typedef logic signed [15:0] mean_t;
    typedef logic [23:0]        dividend_t;   // Q8.8 numerator

    localparam int       q_frac_bits = 8;
    localparam feature_t feature_max = 16'hffff;   // saturation value
    localparam feature_t form_unity  = 16'h0100;   // 1.0 in Q8.8
    localparam int       div_cycles  = 24;         // one per dividend bit

    typedef logic [$clog2(div_cycles)-1:0] div_iter_t;

    // ==================================================
    // state machines
    // ==================================================
    typedef enum logic {
        idle,
        collect
    } seq_state_t;

    typedef enum logic {
        div_idle,
        div_busy
    } div_state_t;

endpackage

`default_nettype wire

// ==== hdl/window_sequencer.sv ====
// window sample sequencer
`timescale 1ns/1ps
`default_nettype none

module window_sequencer (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  sample_valid,
    output logic window_last
);
    import feature_pkg::*;

    seq_state_t state;
    count_t     index;    // position of the sample now on the input

    // closing sample of the window is being accepted this cycle
    assign window_last = sample_valid && (index == count_t'(window_len - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= idle;
            index <= '0;
        end else if (sample_valid) begin
            case (state)
                idle: begin
                    state <= collect;     // first sample ever is index 0
                    index <= count_t'(1);
                end
                collect: begin
                    index <= index + 1'b1;   // wraps every window_len samples
                end
                default: begin
                    state <= idle;
                    index <= '0;
                end
            endcase
        end
    end

    // index only moves once collecting has begun
    a_idle_index_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == idle) |-> (index == '0) && !window_last
    ) else $error("sequencer idle with index %0d", index);

    // a window boundary is followed by a fresh index 0
    a_wrap_after_last: assert property (
        @(posedge clk) disable iff (!rst_n)
        window_last |=> (index == '0) && (state == collect)
    ) else $error("index did not wrap after window_last");

endmodule

`default_nettype wire

// ==== hdl/window_accumulator.sv ====
// per-window sample accumulator
`timescale 1ns/1ps
`default_nettype none

module window_accumulator (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire feature_pkg::sample_t    sample,
    input  wire                          sample_valid,
    input  wire                          window_last,
    output feature_pkg::sum_t            sum_signal,
    output feature_pkg::sum_t            sum_abs,
    output feature_pkg::sum_t            sum_square,
    output feature_pkg::sample_t         peak_max,
    output feature_pkg::sample_t         peak_min,
    output feature_pkg::feature_t        cross_count,
    output logic                         window_ready
);
    import feature_pkg::*;

    // ==================================================
    // live totals of the window in progress
    // ==================================================
    sum_t     acc_sum;
    sum_t     acc_abs;
    sum_t     acc_sq;
    sample_t  live_max;
    sample_t  live_min;
    feature_t live_cross;
    sample_t  prev_sample;    // last accepted sample, kept across windows

    sum_t     sample_ext;
    sum_t     abs_ext;
    logic     crossed;
    sum_t     nxt_sum;
    sum_t     nxt_abs;
    sum_t     nxt_sq;
    sample_t  nxt_max;
    sample_t  nxt_min;
    feature_t nxt_cross;

    // totals including the sample on the input
    always_comb begin
        sample_ext = sum_t'(sample);
        abs_ext    = sample[sample_bits-1] ? -sample_ext : sample_ext;
        crossed    = sample[sample_bits-1] != prev_sample[sample_bits-1];
        nxt_sum    = acc_sum + sample_ext;
        nxt_abs    = acc_abs + abs_ext;
        nxt_sq     = acc_sq + sample_ext * sample_ext;
        nxt_max    = (sample > live_max) ? sample : live_max;
        nxt_min    = (sample < live_min) ? sample : live_min;
        nxt_cross  = live_cross + feature_t'(crossed);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_sum     <= '0;
            acc_abs     <= '0;
            acc_sq      <= '0;
            live_max    <= sample_min;
            live_min    <= sample_max;
            live_cross  <= '0;
            prev_sample <= '0;
        end else if (sample_valid) begin
            prev_sample <= sample;
            if (window_last) begin
                // closing sample went into the snapshot, start empty
                acc_sum    <= '0;
                acc_abs    <= '0;
                acc_sq     <= '0;
                live_max   <= sample_min;
                live_min   <= sample_max;
                live_cross <= '0;
            end else begin
                acc_sum    <= nxt_sum;
                acc_abs    <= nxt_abs;
                acc_sq     <= nxt_sq;
                live_max   <= nxt_max;
                live_min   <= nxt_min;
                live_cross <= nxt_cross;
            end
        end
    end

    // ==================================================
    // window snapshot
    // ==================================================
    always_ff @(posedge clk) begin
        if (sample_valid && window_last) begin
            sum_signal  <= nxt_sum;
            sum_abs     <= nxt_abs;
            sum_square  <= nxt_sq;
            peak_max    <= nxt_max;
            peak_min    <= nxt_min;
            cross_count <= nxt_cross;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            window_ready <= 1'b0;
        end else begin
            window_ready <= sample_valid && window_last;   // snapshot is stable
        end
    end

    a_peak_order: assert property (
        @(posedge clk) disable iff (!rst_n)
        window_ready |-> (peak_max >= peak_min)
    ) else $error("snapshot peak_max %h below peak_min %h", peak_max, peak_min);

endmodule

`default_nettype wire

// ==== hdl/ratio_divider.sv ====
// serial restoring divider
`timescale 1ns/1ps
`default_nettype none

module ratio_divider (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          start,
    input  wire feature_pkg::dividend_t  dividend,
    input  wire feature_pkg::feature_t   divisor,
    input  wire feature_pkg::feature_t   zero_result,
    output feature_pkg::feature_t        quotient,
    output logic                         done
);
    import feature_pkg::*;

    localparam int dq_bits = $bits(dividend_t);

    div_state_t state;
    div_iter_t  iter;       // steps already taken
    feature_t   rem;        // partial remainder
    dividend_t  dq;         // dividend bits out at the top, quotient bits in
    feature_t   div_held;

    feature_t               src_rem;
    dividend_t              src_dq;
    feature_t               src_div;
    logic [$bits(feature_t):0] shifted;
    logic                   fits;
    feature_t               nxt_rem;
    dividend_t              nxt_dq;

    // one restoring step, the first one runs on the start edge itself
    always_comb begin
        src_rem = (state == div_busy) ? rem : '0;
        src_dq  = (state == div_busy) ? dq : dividend;
        src_div = (state == div_busy) ? div_held : divisor;
        shifted = {src_rem, src_dq[dq_bits-1]};
        fits    = shifted >= {1'b0, src_div};
        nxt_rem = fits ? feature_t'(shifted - {1'b0, src_div}) : shifted[$bits(feature_t)-1:0];
        nxt_dq  = {src_dq[dq_bits-2:0], fits};
    end

    always_ff @(posedge clk) begin
        if (state == div_busy || start) begin
            rem <= nxt_rem;
            dq  <= nxt_dq;
        end
        if (state == div_idle && start) begin
            div_held <= divisor;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= div_idle;
            iter     <= '0;
            quotient <= '0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                div_idle: begin
                    if (start) begin
                        state <= div_busy;
                        iter  <= div_iter_t'(1);
                    end
                end
                div_busy: begin
                    iter <= iter + 1'b1;
                    if (iter == div_iter_t'(div_cycles - 1)) begin
                        state <= div_idle;
                        done  <= 1'b1;
                        if (div_held == '0) begin
                            quotient <= zero_result;
                        end else if (|nxt_dq[dq_bits-1:$bits(feature_t)]) begin
                            quotient <= feature_max;    // wider than 16 bits
                        end else begin
                            quotient <= nxt_dq[$bits(feature_t)-1:0];
                        end
                    end
                end
                default: state <= div_idle;
            endcase
        end
    end

    a_start_when_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        start |-> (state == div_idle)
    ) else $error("divider started while busy");

    // fixed latency, the formatter counts on it
    a_fixed_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        start |-> ##div_cycles done
    ) else $error("divider done not %0d cycles after start", div_cycles);

endmodule

`default_nettype wire

// ==== hdl/feature_formatter.sv ====
// feature ratio and output stage
`timescale 1ns/1ps
`default_nettype none

module feature_formatter (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          window_ready,
    input  wire feature_pkg::sum_t       sum_signal,
    input  wire feature_pkg::sum_t       sum_abs,
    input  wire feature_pkg::sum_t       sum_square,
    input  wire feature_pkg::sample_t    peak_max,
    input  wire feature_pkg::sample_t    peak_min,
    input  wire feature_pkg::feature_t   cross_count,
    output feature_pkg::feature_t        zcr,
    output feature_pkg::feature_t        crest_factor,
    output feature_pkg::feature_t        form_factor,
    output feature_pkg::feature_t        peak_to_peak,
    output feature_pkg::feature_t        std_dev,
    output feature_pkg::mean_t           mean_value,
    output logic                         features_valid
);
    import feature_pkg::*;

    // window average of a non-negative total, saturated
    function automatic feature_t window_avg(input sum_t total);
        sum_t avg;
        avg = total >>> window_shift;
        return (|avg[31:16]) ? feature_max : avg[15:0];
    endfunction

    sum_t      mean_full;
    feature_t  span_now;
    feature_t  abs_now;
    feature_t  sq_now;

    feature_t  hold_cross;
    mean_t     hold_mean;
    feature_t  hold_span;
    feature_t  hold_abs;
    feature_t  hold_sq;
    dividend_t crest_num;
    dividend_t form_num;
    logic      div_start;
    feature_t  crest_q;
    feature_t  form_q;
    logic      crest_done;
    logic      form_done;

    always_comb begin
        mean_full = sum_signal >>> window_shift;   // arithmetic, keeps sign
        span_now  = feature_t'(sum_t'(peak_max) - sum_t'(peak_min));
        abs_now   = window_avg(sum_abs);
        sq_now    = window_avg(sum_square);
    end

    // ==================================================
    // operands, held until the dividers finish
    // ==================================================
    always_ff @(posedge clk) begin
        if (window_ready) begin
            hold_cross <= cross_count;
            hold_mean  <= mean_t'(mean_full);
            hold_span  <= span_now;
            hold_abs   <= abs_now;
            hold_sq    <= sq_now;
            crest_num  <= dividend_t'(span_now) << q_frac_bits;
            form_num   <= dividend_t'(sq_now) << q_frac_bits;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_start <= 1'b0;
        end else begin
            div_start <= window_ready;
        end
    end

    // span over mean square
    ratio_divider u_crest_div (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (div_start),
        .dividend    (crest_num),
        .divisor     (hold_sq),
        .zero_result (feature_max),
        .quotient    (crest_q),
        .done        (crest_done)
    );

    // mean square over mean absolute value
    ratio_divider u_form_div (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (div_start),
        .dividend    (form_num),
        .divisor     (hold_abs),
        .zero_result (form_unity),
        .quotient    (form_q),
        .done        (form_done)
    );

    // ==================================================
    // feature outputs
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            zcr            <= '0;
            crest_factor   <= '0;
            form_factor    <= '0;
            peak_to_peak   <= '0;
            std_dev        <= '0;
            mean_value     <= '0;
            features_valid <= 1'b0;
        end else begin
            features_valid <= crest_done && form_done;
            if (crest_done && form_done) begin
                zcr          <= hold_cross;
                crest_factor <= crest_q;
                form_factor  <= form_q;
                peak_to_peak <= hold_span;
                std_dev      <= hold_sq;     // mean square stands in for std dev
                mean_value   <= hold_mean;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/waveform_features.sv ====
// waveform feature extractor top
`timescale 1ns/1ps
`default_nettype none

module waveform_features (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire feature_pkg::sample_t    sample,
    input  wire                          sample_valid,
    output feature_pkg::feature_t        zcr,
    output feature_pkg::mean_t           mean_value,
    output feature_pkg::feature_t        peak_to_peak,
    output feature_pkg::feature_t        std_dev,
    output feature_pkg::feature_t        crest_factor,
    output feature_pkg::feature_t        form_factor,
    output logic                         features_valid
);
    import feature_pkg::*;

    logic     window_last;
    logic     window_ready;
    sum_t     sum_signal;
    sum_t     sum_abs;
    sum_t     sum_square;
    sample_t  peak_max;
    sample_t  peak_min;
    feature_t cross_count;

    window_sequencer u_window_sequencer (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample_valid (sample_valid),
        .window_last  (window_last)
    );

    window_accumulator u_window_accumulator (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample       (sample),
        .sample_valid (sample_valid),
        .window_last  (window_last),
        .sum_signal   (sum_signal),
        .sum_abs      (sum_abs),
        .sum_square   (sum_square),
        .peak_max     (peak_max),
        .peak_min     (peak_min),
        .cross_count  (cross_count),
        .window_ready (window_ready)
    );

    feature_formatter u_feature_formatter (
        .clk            (clk),
        .rst_n          (rst_n),
        .window_ready   (window_ready),
        .sum_signal     (sum_signal),
        .sum_abs        (sum_abs),
        .sum_square     (sum_square),
        .peak_max       (peak_max),
        .peak_min       (peak_min),
        .cross_count    (cross_count),
        .zcr            (zcr),
        .crest_factor   (crest_factor),
        .form_factor    (form_factor),
        .peak_to_peak   (peak_to_peak),
        .std_dev        (std_dev),
        .mean_value     (mean_value),
        .features_valid (features_valid)
    );

endmodule

`default_nettype wire

// ==== sim/tb_waveform_features.sv ====
// waveform feature extractor testbench
`timescale 1ns/1ps
`default_nettype none

module tb_waveform_features;
    import feature_pkg::*;

    localparam int clk_period     = 100;
    localparam int latency        = 26;     // last sample edge to features_valid
    localparam int total_windows  = 9;
    localparam int timeout_cycles = total_windows * window_len * 2 + 400;

    localparam int mode_zero    = 0;
    localparam int mode_square  = 1;
    localparam int mode_random  = 2;
    localparam int mode_biased  = 3;   // random, pulled negative
    localparam int mode_impulse = 4;   // one negative sample, rest zero

    logic     clk;
    logic     rst_n;
    sample_t  sample;
    logic     sample_valid;
    feature_t zcr;
    mean_t    mean_value;
    feature_t peak_to_peak;
    feature_t std_dev;
    feature_t crest_factor;
    feature_t form_factor;
    logic     features_valid;

    int       errors;
    int       pushes;
    int       pops;
    integer   seed;
    logic     last_accept;            // sample on the input closes a window
    logic [latency:0] lat_pipe;

    // reference model of the window in progress
    longint   m_sum;
    longint   m_abs;
    longint   m_sq;
    int       m_max;
    int       m_min;
    int       m_cross;
    int       m_prev;                 // carried across windows
    int       m_count;

    logic [95:0] exp_q[$];
    feature_t exp_zcr;
    mean_t    exp_mean;
    feature_t exp_span;
    feature_t exp_sd;
    feature_t exp_crest;
    feature_t exp_form;

    waveform_features u_waveform_features (
        .clk            (clk),
        .rst_n          (rst_n),
        .sample         (sample),
        .sample_valid   (sample_valid),
        .zcr            (zcr),
        .mean_value     (mean_value),
        .peak_to_peak   (peak_to_peak),
        .std_dev        (std_dev),
        .crest_factor   (crest_factor),
        .form_factor    (form_factor),
        .features_valid (features_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // ==================================================
    // reference model
    // ==================================================
    function automatic feature_t saturate(input longint value);
        return (value > longint'(feature_max)) ? feature_max : feature_t'(value);
    endfunction

    task automatic clear_window();
        m_sum   = 0;
        m_abs   = 0;
        m_sq    = 0;
        m_max   = -4096;
        m_min   = 4096;
        m_cross = 0;
        m_count = 0;
    endtask

    task automatic load_head();
        {exp_zcr, exp_mean, exp_span, exp_sd, exp_crest, exp_form} = exp_q[0];
    endtask

    task automatic close_window();
        longint   span;
        feature_t mean_abs;
        feature_t mean_sq;
        feature_t crest;
        feature_t form;
        mean_t    mean;
        span     = longint'(m_max - m_min);
        mean     = mean_t'(m_sum >>> window_shift);    // floors negative sums
        mean_abs = saturate(m_abs >>> window_shift);
        mean_sq  = saturate(m_sq >>> window_shift);
        if (mean_sq == '0) crest = feature_max;
        else crest = saturate((span << q_frac_bits) / longint'(mean_sq));
        if (mean_abs == '0) form = form_unity;
        else form = saturate((longint'(mean_sq) << q_frac_bits) / longint'(mean_abs));
        exp_q.push_back({feature_t'(m_cross), mean, feature_t'(span), mean_sq, crest, form});
        pushes++;
        if (exp_q.size() == 1) load_head();
        clear_window();
    endtask

    task automatic model_accept(input sample_t value);
        int v;
        v = int'(value);
        if ((v < 0) != (m_prev < 0)) m_cross++;   // sign change
        m_prev = v;
        m_sum  = m_sum + longint'(v);
        m_abs  = m_abs + longint'((v < 0) ? -v : v);
        m_sq   = m_sq + longint'(v) * longint'(v);
        if (v > m_max) m_max = v;
        if (v < m_min) m_min = v;
        last_accept = (m_count == window_len - 1);
        m_count++;
        if (last_accept) close_window();
    endtask

    // ==================================================
    // stimulus
    // ==================================================
    task automatic drive_step(input sample_t value, input logic valid);
        @(posedge clk);
        #1;
        sample       = value;
        sample_valid = valid;
        last_accept  = 1'b0;
        if (valid) model_accept(value);
    endtask

    task automatic drive_window(input int mode, input int amp, input bit gaps);
        int      accepted;
        int      raw;
        logic    valid;
        sample_t value;
        accepted = 0;
        while (accepted < window_len) begin
            raw   = $random(seed);
            valid = gaps ? (raw[1:0] != 2'b00) : 1'b1;    // about one gap in four
            case (mode)
                mode_square:  value = accepted[0] ? sample_t'(amp) : sample_t'(-amp);
                mode_random:  value = sample_t'($random(seed));
                mode_biased:  value = sample_t'(($random(seed) % 512) - amp);
                mode_impulse: value = (accepted == 0) ? sample_t'(-amp) : '0;
                default:      value = '0;
            endcase
            drive_step(value, valid);
            if (valid) accepted++;
        end
    endtask

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lat_pipe <= '0;
        end else begin
            lat_pipe <= {lat_pipe[latency-1:0], last_accept};
        end
    end

    // result consumed once the pulse is over
    always @(negedge features_valid) begin
        if (exp_q.size() > 0) begin
            exp_q.delete(0);
            pops++;
            if (exp_q.size() > 0) load_head();
        end
    end

    // ==================================================
    // checks
    // ==================================================
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        features_valid == lat_pipe[latency])
    else begin
        errors++;
        $display("error features_valid got %h expected %h",
                 $sampled(features_valid), $sampled(lat_pipe[latency]));
    end

    a_quiet_start: assert property (@(posedge clk) disable iff (!rst_n)
        (pops == 0 && !lat_pipe[latency]) |->
        (zcr == '0 && mean_value == '0 && peak_to_peak == '0 && std_dev == '0 &&
         crest_factor == '0 && form_factor == '0))
    else begin
        errors++;
        $display("error zcr %h mean_value %h peak_to_peak %h expected 0000",
                 $sampled(zcr), $sampled(mean_value), $sampled(peak_to_peak));
        $display("error std_dev %h crest_factor %h form_factor %h expected 0000",
                 $sampled(std_dev), $sampled(crest_factor), $sampled(form_factor));
    end

    a_zcr: assert property (@(posedge clk) disable iff (!rst_n)
        features_valid |-> zcr == exp_zcr)
    else begin
        errors++;
        $display("error zcr got %h expected %h", $sampled(zcr), $sampled(exp_zcr));
    end

    a_mean: assert property (@(posedge clk) disable iff (!rst_n)
        features_valid |-> mean_value == exp_mean)
    else begin
        errors++;
        $display("error mean_value got %h expected %h",
                 $sampled(mean_value), $sampled(exp_mean));
    end

    a_span: assert property (@(posedge clk) disable iff (!rst_n)
        features_valid |-> peak_to_peak == exp_span)
    else begin
        errors++;
        $display("error peak_to_peak got %h expected %h",
                 $sampled(peak_to_peak), $sampled(exp_span));
    end

    a_std_dev: assert property (@(posedge clk) disable iff (!rst_n)
        features_valid |-> std_dev == exp_sd)
    else begin
        errors++;
        $display("error std_dev got %h expected %h", $sampled(std_dev), $sampled(exp_sd));
    end

    a_crest: assert property (@(posedge clk) disable iff (!rst_n)
        features_valid |-> crest_factor == exp_crest)
    else begin
        errors++;
        $display("error crest_factor got %h expected %h",
                 $sampled(crest_factor), $sampled(exp_crest));
    end

    a_form: assert property (@(posedge clk) disable iff (!rst_n)
        features_valid |-> form_factor == exp_form)
    else begin
        errors++;
        $display("error form_factor got %h expected %h",
                 $sampled(form_factor), $sampled(exp_form));
    end

    // ==================================================
    // test sequence
    // ==================================================
    initial begin
        seed         = 32'he791;
        errors       = 0;
        pushes       = 0;
        pops         = 0;
        rst_n        = 1'b0;
        sample       = '0;
        sample_valid = 1'b0;
        last_accept  = 1'b0;
        m_prev       = 0;
        clear_window();
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (4) drive_step('0, 1'b0);

        // back to back windows
        drive_window(mode_zero, 0, 1'b0);
        drive_window(mode_square, 300, 1'b0);
        drive_window(mode_square, 3, 1'b0);
        drive_window(mode_random, 0, 1'b0);
        drive_window(mode_biased, 300, 1'b0);
        drive_window(mode_impulse, 1024, 1'b0);   // form factor quotient overflows
        // windows with sample_valid gaps
        drive_window(mode_random, 0, 1'b1);
        drive_window(mode_square, 40, 1'b1);
        drive_window(mode_biased, 100, 1'b1);
        drive_step('0, 1'b0);

        while (pops < pushes) @(posedge clk);
        repeat (4) @(posedge clk);
        if (pops != total_windows) begin
            errors++;
            $display("only %0d of %0d windows produced features", pops, total_windows);
        end
        $display("%0d windows checked, %0d errors", pops, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        #(timeout_cycles * clk_period);
        $display("watchdog expired after %0d cycles, features still outstanding", timeout_cycles);
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
hdl/feature_pkg.sv
hdl/window_sequencer.sv
hdl/window_accumulator.sv
hdl/ratio_divider.sv
hdl/feature_formatter.sv
hdl/waveform_features.sv
sim/tb_waveform_features.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the waveform feature testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found on PATH"
    exit 1
fi

verilator --binary --timing --assert -f sources.f \
    --top-module tb_waveform_features -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_tb 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "All tests passed"; then
    exit 0
fi
exit 1
